//--- build.f
+incdir+.
emmc_link_pkg.sv
emmc_frame_packer.sv
lane_serializer.sv
lane_deserializer.sv
bitslip_aligner.sv
emmc_frame_unpacker.sv
emmc_serdes_link.sv
tb_emmc_link.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the eMMC serial link testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_emmc_link -f build.f

# Keep the exit status so the log search always runs
status=0
./obj_dir/Vtb_emmc_link > sim.log 2>&1 || status=$?
cat sim.log

if grep -q "TESTBENCH FAILED" sim.log || [ "$status" -ne 0 ]; then
    echo "simulation failed, see sim.log"
    exit 1
fi
echo "simulation finished without failures"

//--- tb_emmc_link_checks.svh
`ifndef TB_EMMC_LINK_CHECKS_SVH
`define TB_EMMC_LINK_CHECKS_SVH

// Running counts, test_errs restarts with every test
int checks    = 0;
int test_errs = 0;
int err_total = 0;
int tests_ok  = 0;
int tests_bad = 0;

////////////////////////////////////////
// Compare tasks
////////////////////////////////////////

task automatic check_bit(input string name, input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
        $display("mismatch %s: got 0x%h expected 0x%h", name, got, exp);
        test_errs++;
    end
endtask

task automatic check_dat(input string name, input emmc_link_pkg::emmc_dat_t got,
                         input emmc_link_pkg::emmc_dat_t exp);
    checks++;
    if (got !== exp) begin
        $display("mismatch %s: got 0x%h expected 0x%h", name, got, exp);
        test_errs++;
    end
endtask

task automatic check_word(input string name, input emmc_link_pkg::frame_word_t got,
                          input emmc_link_pkg::frame_word_t exp);
    checks++;
    if (got !== exp) begin
        $display("mismatch %s: got 0x%h expected 0x%h", name, got, exp);
        test_errs++;
    end
endtask

// Protocol and timing faults with no value to compare
task automatic report_fail(input string what);
    $display("failure: %s", what);
    test_errs++;
endtask

// One summary line per finished test
task automatic close_test(input int idx, input int delay, input int sent, input int got);
    $display("test %0d lane_delay %0d sent %0d received %0d errors %0d %s",
             idx, delay, sent, got, test_errs, (test_errs == 0) ? "ok" : "bad");
    if (test_errs == 0) begin
        tests_ok++;
    end else begin
        tests_bad++;
    end
    err_total += test_errs;
    test_errs = 0;
endtask

`endif

//--- tb_emmc_link.sv
`timescale 1ns/1ps

module tb_emmc_link;

    localparam int LOCK_WAIT_FRAMES = 2;
    localparam int FRAME_CYCLES     = 8;                            // One serial bit per clock
    localparam int LOCK_BOUND       = 8 * (LOCK_WAIT_FRAMES + 2) * FRAME_CYCLES;
    localparam int NUM_TESTS        = 8;                            // One per lane delay
    localparam int WORDS            = 24;                           // Host words per test
    localparam int RESET_CYCLES     = 4;
    localparam int ACK_TIMEOUT      = 20;
    localparam int DRAIN_CYCLES     = 40;                           // Frame, lane delay, pipeline
    localparam int IDLE_CYCLES      = 3 * FRAME_CYCLES;
    localparam int WATCHDOG_CYCLES  = NUM_TESTS * (LOCK_BOUND + WORDS * 20);
    localparam emmc_link_pkg::frame_word_t TRAIN_WORD = 8'hC3;      // Training lane content

    logic                       txclk_div;
    logic                       rst;
    logic                       tx_req, tx_cmd, tx_cmd_oe, tx_dat_oe, tx_ack;
    emmc_link_pkg::emmc_dat_t   tx_dat;
    logic                       ser_train, ser_data;                // DUT lane outputs
    logic                       ser_train_in, ser_data_in;          // Delayed lanes back in
    logic                       rx_valid, rx_cmd, rx_cmd_oe, rx_dat_oe, rx_locked;
    emmc_link_pkg::emmc_dat_t   rx_dat;
    logic [2:0]                 lane_delay;
    logic [6:0]                 train_dly = '1;                     // Lines idle high
    logic [6:0]                 data_dly  = '1;
    logic [7:0]                 train_taps;                         // Tap k is k cycles late
    logic [7:0]                 data_taps;
    emmc_link_pkg::frame_word_t model_q[$];                         // Acked words in order
    emmc_link_pkg::frame_word_t exp_word;
    logic                       ack_prev    = 1'b0;
    logic                       locked_prev = 1'b0;
    int                         acked       = 0;
    int                         received    = 0;

    `include "tb_emmc_link_checks.svh"

    always #5 txclk_div = ~txclk_div;

    emmc_serdes_link #(.LOCK_WAIT_FRAMES(LOCK_WAIT_FRAMES)) dut0 (
        .txclk_div(txclk_div), .rst(rst),
        .tx_req_i(tx_req), .tx_cmd_i(tx_cmd), .tx_cmd_oe_i(tx_cmd_oe),
        .tx_dat_oe_i(tx_dat_oe), .tx_dat_i(tx_dat), .tx_ack_o(tx_ack),
        .ser_train_o(ser_train), .ser_data_o(ser_data),
        .ser_train_i(ser_train_in), .ser_data_i(ser_data_in),
        .rx_valid_o(rx_valid), .rx_cmd_o(rx_cmd), .rx_cmd_oe_o(rx_cmd_oe),
        .rx_dat_oe_o(rx_dat_oe), .rx_dat_o(rx_dat), .rx_locked_o(rx_locked)
    );

    ////////////////////////////////////////
    // Lane delay loopback
    ////////////////////////////////////////

    always @(posedge txclk_div) begin
        train_dly <= {train_dly[5:0], ser_train};
        data_dly  <= {data_dly[5:0], ser_data};
    end

    // Tap 0 is the direct wire
    assign train_taps = {train_dly, ser_train};
    assign data_taps  = {data_dly, ser_data};

    assign ser_train_in = train_taps[lane_delay];
    assign ser_data_in  = data_taps[lane_delay];

    ////////////////////////////////////////
    // Monitor and model
    ////////////////////////////////////////

    always @(negedge txclk_div) begin
        if (tx_ack && !ack_prev) begin                              // Word accepted
            if (!tx_req) begin
                report_fail("tx_ack_o rose while tx_req_i was low");
            end
            model_q.push_back({1'b1, tx_cmd, tx_cmd_oe, tx_dat_oe, tx_dat});
            acked++;
        end
        if (!tx_ack && ack_prev && tx_req) begin
            report_fail("tx_ack_o fell while tx_req_i was still high");
        end
        if (rx_valid) begin
            if (model_q.size() == 0) begin
                report_fail("rx_valid_o pulsed with no word outstanding");
            end else begin
                exp_word = model_q.pop_front();
                check_bit("rx_cmd_o", rx_cmd, exp_word[emmc_link_pkg::CMD_BIT]);
                check_bit("rx_cmd_oe_o", rx_cmd_oe, exp_word[emmc_link_pkg::CMD_OE_BIT]);
                check_bit("rx_dat_oe_o", rx_dat_oe, exp_word[emmc_link_pkg::DAT_OE_BIT]);
                check_dat("rx_dat_o", rx_dat, exp_word[3:0]);
                received++;
            end
        end
        if (rx_locked && dut0.word_stb) begin                       // Aligned boundary holds
            check_word("train_word", dut0.rx_train_word, TRAIN_WORD);
        end
        if (locked_prev && !rx_locked && rst) begin
            report_fail("rx_locked_o dropped without reset");
        end
        ack_prev    = tx_ack;
        locked_prev = rx_locked;
    end

    ////////////////////////////////////////
    // Sequence tasks
    ////////////////////////////////////////

    task automatic apply_reset(input logic [2:0] delay);
        @(negedge txclk_div);
        rst        = 1'b0;
        tx_req     = 1'b0;
        lane_delay = delay;                                         // New delay under reset
        repeat (RESET_CYCLES) begin
            @(negedge txclk_div);
            check_bit("tx_ack_o", tx_ack, 1'b0);
            check_bit("rx_valid_o", rx_valid, 1'b0);
            check_bit("rx_locked_o", rx_locked, 1'b0);
            check_bit("ser_train_o", ser_train, 1'b1);              // Lanes idle high
            check_bit("ser_data_o", ser_data, 1'b1);
        end
        rst = 1'b1;
    endtask

    task automatic wait_lock();
        int n;
        n = 0;
        while (!rx_locked && n < LOCK_BOUND) begin
            @(negedge txclk_div);
            n++;
        end
        if (!rx_locked) begin
            report_fail($sformatf("rx_locked_o not high within %0d cycles", LOCK_BOUND));
        end
    endtask

    task automatic send_word();
        int n;
        tx_cmd    = 1'($urandom);
        tx_cmd_oe = 1'($urandom);
        tx_dat_oe = 1'($urandom);
        tx_dat    = emmc_link_pkg::emmc_dat_t'($urandom);
        tx_req    = 1'b1;
        n = 0;
        while (!tx_ack && n < ACK_TIMEOUT) begin
            @(negedge txclk_div);
            n++;
        end
        if (!tx_ack) begin
            report_fail("tx_ack_o never rose for a pending request");
        end else if (n < 2 || n > 9) begin
            report_fail($sformatf("tx_ack_o took %0d cycles, outside 2 to 9", n));
        end
        @(negedge txclk_div);                                       // Req drops a cycle after ack
        tx_req = 1'b0;
        n = 0;
        while (tx_ack && n < ACK_TIMEOUT) begin
            @(negedge txclk_div);
            n++;
        end
        if (tx_ack) begin
            report_fail("tx_ack_o stayed high after tx_req_i fell");
        end
        @(negedge txclk_div);
        repeat ($urandom_range(3, 0)) @(negedge txclk_div);         // Idle gap
    endtask

    task automatic drain_words();
        int n;
        n = 0;
        while (model_q.size() != 0 && n < DRAIN_CYCLES) begin
            @(negedge txclk_div);
            n++;
        end
        if (model_q.size() != 0) begin
            report_fail($sformatf("%0d words never arrived on rx_valid_o", model_q.size()));
            model_q.delete();
        end
    endtask

    initial begin
        txclk_div  = 1'b0;
        rst        = 1'b0;
        tx_req     = 1'b0;
        tx_cmd     = 1'b0;
        tx_cmd_oe  = 1'b0;
        tx_dat_oe  = 1'b0;
        tx_dat     = '0;
        lane_delay = '0;
        void'($urandom(32'h40f83a13));
        for (int t = 0; t < NUM_TESTS; t++) begin
            apply_reset(3'(t));                                     // Mid-run reset from test 1
            wait_lock();
            repeat (WORDS) send_word();
            drain_words();
            repeat (IDLE_CYCLES) @(negedge txclk_div);              // Idle link with rx_valid_o low
            close_test(t, t, acked, received);
            acked    = 0;
            received = 0;
        end
        $display("summary: tests %0d passed %0d failed %0d checks %0d errors %0d",
                 NUM_TESTS, tests_ok, tests_bad, checks, err_total);
        if (err_total == 0 && tests_bad == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

    // Run limit scales with lock bound and word count
    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge txclk_div);
        $display("watchdog: run exceeded %0d cycles", WATCHDOG_CYCLES);
        $display("TESTBENCH FAILED");
        $finish;
    end

endmodule

//--- emmc_serdes_link.sv
`timescale 1ns/1ps

module emmc_serdes_link #(
    parameter int LOCK_WAIT_FRAMES = 2   // Settle strobes after each slip
) (
    input  logic                     txclk_div,
    input  logic                     rst,          // Synchronous, active low
    // Host transmit side
    input  logic                     tx_req_i,
    input  logic                     tx_cmd_i,
    input  logic                     tx_cmd_oe_i,
    input  logic                     tx_dat_oe_i,
    input  emmc_link_pkg::emmc_dat_t tx_dat_i,
    output logic                     tx_ack_o,
    // Serial lanes
    output logic                     ser_train_o,
    output logic                     ser_data_o,
    input  logic                     ser_train_i,
    input  logic                     ser_data_i,
    // Receive side
    output logic                     rx_valid_o,
    output logic                     rx_cmd_o,
    output logic                     rx_cmd_oe_o,
    output logic                     rx_dat_oe_o,
    output emmc_link_pkg::emmc_dat_t rx_dat_o,
    output logic                     rx_locked_o
);

    logic                       frame_start;   // Serializer to packer
    emmc_link_pkg::frame_word_t tx_word;       // Packer to serializer
    emmc_link_pkg::frame_word_t rx_train_word; // Deserializer to aligner
    emmc_link_pkg::frame_word_t rx_data_word;  // Deserializer to unpacker
    logic                       word_stb;
    logic                       slip;

    ////////////////////////////////////////
    // Transmitter
    ////////////////////////////////////////

    emmc_frame_packer u_packer (
        .txclk_div     (txclk_div),
        .rst           (rst),
        .frame_start_i (frame_start),
        .tx_req_i      (tx_req_i),
        .tx_cmd_i      (tx_cmd_i),
        .tx_cmd_oe_i   (tx_cmd_oe_i),
        .tx_dat_oe_i   (tx_dat_oe_i),
        .tx_dat_i      (tx_dat_i),
        .tx_ack_o      (tx_ack_o),
        .data_word_o   (tx_word)
    );

    lane_serializer u_serializer (
        .txclk_div     (txclk_div),
        .rst           (rst),
        .data_word_i   (tx_word),
        .frame_start_o (frame_start),
        .ser_train_o   (ser_train_o),
        .ser_data_o    (ser_data_o)
    );

    ////////////////////////////////////////
    // Receiver
    ////////////////////////////////////////

    lane_deserializer u_deserializer (
        .txclk_div    (txclk_div),
        .rst          (rst),
        .ser_train_i  (ser_train_i),
        .ser_data_i   (ser_data_i),
        .slip_i       (slip),
        .train_word_o (rx_train_word),
        .data_word_o  (rx_data_word),
        .word_stb_o   (word_stb)
    );

    bitslip_aligner #(
        .LOCK_WAIT_FRAMES (LOCK_WAIT_FRAMES)
    ) u_aligner (
        .txclk_div    (txclk_div),
        .rst          (rst),
        .word_stb_i   (word_stb),
        .train_word_i (rx_train_word),
        .slip_o       (slip),
        .locked_o     (rx_locked_o)    // Also gates the unpacker
    );

    emmc_frame_unpacker u_unpacker (
        .txclk_div   (txclk_div),
        .rst         (rst),
        .word_stb_i  (word_stb),
        .locked_i    (rx_locked_o),
        .data_word_i (rx_data_word),
        .rx_valid_o  (rx_valid_o),
        .rx_cmd_o    (rx_cmd_o),
        .rx_cmd_oe_o (rx_cmd_oe_o),
        .rx_dat_oe_o (rx_dat_oe_o),
        .rx_dat_o    (rx_dat_o)
    );

endmodule

//--- emmc_frame_unpacker.sv
`timescale 1ns/1ps

module emmc_frame_unpacker (
    input  logic                       txclk_div,
    input  logic                       rst,          // Synchronous, active low
    input  logic                       word_stb_i,   // Boundary strobe
    input  logic                       locked_i,     // Aligner lock
    input  emmc_link_pkg::frame_word_t data_word_i,  // Aligned data lane word
    output logic                       rx_valid_o,   // One-cycle field strobe
    output logic                       rx_cmd_o,
    output logic                       rx_cmd_oe_o,
    output logic                       rx_dat_oe_o,
    output emmc_link_pkg::emmc_dat_t   rx_dat_o
);

    logic take;  // Word carries host fields

    // Idle words and pre-lock garbage are dropped here
    assign take = word_stb_i && locked_i && data_word_i[emmc_link_pkg::VALID_BIT];

    always_ff @(posedge txclk_div) begin
        if (!rst) begin
            rx_valid_o <= 1'b0;
        end else begin
            rx_valid_o <= take;                             // No back-pressure
        end
    end

    // Field registers follow the strobe
    always_ff @(posedge txclk_div) begin
        if (take) begin
            rx_cmd_o    <= data_word_i[emmc_link_pkg::CMD_BIT];
            rx_cmd_oe_o <= data_word_i[emmc_link_pkg::CMD_OE_BIT];
            rx_dat_oe_o <= data_word_i[emmc_link_pkg::DAT_OE_BIT];
            rx_dat_o    <= data_word_i[emmc_link_pkg::DAT_HI:emmc_link_pkg::DAT_LO];
        end
    end

    // Strobes from the deserializer are a frame apart
    a_valid_one_cycle: assert property (@(posedge txclk_div) disable iff (!rst)
        rx_valid_o |=> !rx_valid_o)
        else $error("rx_valid_o held longer than one cycle");

endmodule

//--- bitslip_aligner.sv
`timescale 1ns/1ps

module bitslip_aligner #(
    parameter int LOCK_WAIT_FRAMES = 2   // Strobes skipped after each slip
) (
    input  logic                       txclk_div,
    input  logic                       rst,          // Synchronous, active low
    input  logic                       word_stb_i,   // Boundary strobe from deserializer
    input  emmc_link_pkg::frame_word_t train_word_i, // Training word at that boundary
    output logic                       slip_o,       // One-cycle slip request
    output logic                       locked_o      // Boundary found
);

    // Counter holds 1 to LOCK_WAIT_FRAMES-1
    localparam int WAIT_W = (LOCK_WAIT_FRAMES > 1) ? $clog2(LOCK_WAIT_FRAMES) : 1;
    localparam logic [WAIT_W-1:0] WAIT_LAST = WAIT_W'(LOCK_WAIT_FRAMES - 1);

    emmc_link_pkg::align_state_t state;
    logic [WAIT_W-1:0]           wait_cnt;  // Strobes seen since the slip

    ////////////////////////////////////////
    // Slip and wait FSM
    ////////////////////////////////////////

    always_ff @(posedge txclk_div) begin
        if (!rst) begin
            state    <= emmc_link_pkg::WAIT_A;  // Let the lanes fill before the first check
            wait_cnt <= '0;
            slip_o   <= 1'b0;
            locked_o <= 1'b0;
        end else begin
            case (state)
                emmc_link_pkg::SLIP: begin
                    slip_o <= 1'b0;                         // Single pulse only
                    state  <= emmc_link_pkg::WAIT_A;
                end
                emmc_link_pkg::WAIT_A: begin
                    if (word_stb_i) begin
                        wait_cnt <= WAIT_W'(1);
                        if (LOCK_WAIT_FRAMES == 1) begin
                            state <= emmc_link_pkg::CHECK;
                        end else begin
                            state <= emmc_link_pkg::WAIT_B;
                        end
                    end
                end
                emmc_link_pkg::WAIT_B: begin
                    if (word_stb_i) begin
                        if (wait_cnt == WAIT_LAST) begin
                            state <= emmc_link_pkg::CHECK;  // Next strobe gets compared
                        end else begin
                            wait_cnt <= wait_cnt + 1'b1;
                        end
                    end
                end
                emmc_link_pkg::CHECK: begin
                    if (word_stb_i) begin
                        if (train_word_i == emmc_link_pkg::TRAIN_PATTERN) begin
                            state    <= emmc_link_pkg::LOCKED;
                            locked_o <= 1'b1;
                        end else begin
                            state  <= emmc_link_pkg::SLIP;  // Try the next bit position
                            slip_o <= 1'b1;
                        end
                    end
                end
                emmc_link_pkg::LOCKED: ;                    // Stays until reset
                default: state <= emmc_link_pkg::WAIT_A;
            endcase
        end
    end

    a_no_slip_locked: assert property (@(posedge txclk_div) disable iff (!rst)
        !(slip_o && locked_o))
        else $error("slip_o high while locked");

endmodule

//--- lane_deserializer.sv
`timescale 1ns/1ps

module lane_deserializer (
    input  logic                       txclk_div,
    input  logic                       rst,          // Synchronous, active low
    input  logic                       ser_train_i,  // Training lane in
    input  logic                       ser_data_i,   // Data lane in
    input  logic                       slip_i,       // Hold counter one cycle
    output emmc_link_pkg::frame_word_t train_word_o, // Parallel training word
    output emmc_link_pkg::frame_word_t data_word_o,  // Parallel data word
    output logic                       word_stb_o    // One cycle per boundary
);

    localparam int FB = emmc_link_pkg::FRAME_BITS;

    emmc_link_pkg::bit_cnt_t bit_cnt;       // Receiver frame position
    logic [FB-2:0]           train_sr;      // Seven older bits, newest bit comes from the pin
    logic [FB-2:0]           data_sr;
    logic                    at_boundary;   // Full word present this cycle

    // A held count never produces a boundary
    assign at_boundary = (bit_cnt == emmc_link_pkg::LAST_BIT) && !slip_i;

    ////////////////////////////////////////
    // Shift-in and word capture
    ////////////////////////////////////////

    always_ff @(posedge txclk_div) begin
        train_sr <= {train_sr[FB-3:0], ser_train_i};        // Shift every cycle, slip or not
        data_sr  <= {data_sr[FB-3:0], ser_data_i};
        if (at_boundary) begin
            train_word_o <= {train_sr, ser_train_i};        // Oldest bit lands in MSB
            data_word_o  <= {data_sr, ser_data_i};
        end
    end

    ////////////////////////////////////////
    // Slippable counter
    ////////////////////////////////////////

    always_ff @(posedge txclk_div) begin
        if (!rst) begin
            bit_cnt    <= '0;
            word_stb_o <= 1'b0;
        end else begin
            if (!slip_i) begin
                bit_cnt <= bit_cnt + 1'b1;                  // Held count moves boundary one bit
            end
            word_stb_o <= at_boundary;                      // Words valid with the strobe
        end
    end

endmodule

//--- lane_serializer.sv
`timescale 1ns/1ps

module lane_serializer (
    input  logic                       txclk_div,
    input  logic                       rst,           // Synchronous, active low
    input  emmc_link_pkg::frame_word_t data_word_i,   // From packer, stable at count zero
    output logic                       frame_start_o, // Last bit of current frame
    output logic                       ser_train_o,   // Training lane, MSB first
    output logic                       ser_data_o     // Data lane, MSB first
);

    emmc_link_pkg::bit_cnt_t    bit_cnt;    // Free running frame position
    emmc_link_pkg::frame_word_t train_sr;   // Training shift register
    emmc_link_pkg::frame_word_t data_sr;    // Data shift register

    // Packer updates its word on this cycle, ready for the load below
    assign frame_start_o = (bit_cnt == emmc_link_pkg::LAST_BIT);

    assign ser_train_o = train_sr[emmc_link_pkg::FRAME_BITS-1];
    assign ser_data_o  = data_sr[emmc_link_pkg::FRAME_BITS-1];

    ////////////////////////////////////////
    // Frame counter and shift-out
    ////////////////////////////////////////

    always_ff @(posedge txclk_div) begin
        if (!rst) begin
            bit_cnt  <= '0;
            train_sr <= '1;                                 // Lines idle high in reset
            data_sr  <= '1;
        end else begin
            bit_cnt <= bit_cnt + 1'b1;                      // Wraps every frame
            if (bit_cnt == '0) begin
                train_sr <= emmc_link_pkg::TRAIN_PATTERN;   // New frame on both lanes
                data_sr  <= data_word_i;
            end else begin
                train_sr <= {train_sr[emmc_link_pkg::FRAME_BITS-2:0], 1'b1};
                data_sr  <= {data_sr[emmc_link_pkg::FRAME_BITS-2:0], 1'b1};
            end
        end
    end

endmodule

//--- emmc_frame_packer.sv
`timescale 1ns/1ps

module emmc_frame_packer (
    input  logic                       txclk_div,
    input  logic                       rst,           // Synchronous, active low
    input  logic                       frame_start_i, // Last bit cycle of the frame on air
    input  logic                       tx_req_i,      // Four-phase request from host
    input  logic                       tx_cmd_i,
    input  logic                       tx_cmd_oe_i,
    input  logic                       tx_dat_oe_i,
    input  emmc_link_pkg::emmc_dat_t   tx_dat_i,
    output logic                       tx_ack_o,      // Four-phase acknowledge
    output emmc_link_pkg::frame_word_t data_word_o    // Next word for the data lane
);

    // Handshake states
    typedef enum logic [1:0] {
        PK_IDLE,     // Free, ack low
        PK_LATCHED,  // Fields taken at the boundary
        PK_ACK       // Ack high until the host drops req
    } pk_state_t;

    pk_state_t                  state;
    logic                       accept;     // Request taken this cycle
    emmc_link_pkg::frame_word_t next_word;  // Word for the coming frame

    // Only a free packer takes a request, and only on a boundary
    assign accept = (state == PK_IDLE) && tx_req_i && frame_start_i;

    assign tx_ack_o = (state == PK_ACK);

    ////////////////////////////////////////
    // Word build
    ////////////////////////////////////////

    always_comb begin
        next_word = '0;                                     // Idle word, valid clear
        if (accept) begin
            next_word[emmc_link_pkg::VALID_BIT]  = 1'b1;
            next_word[emmc_link_pkg::CMD_BIT]    = tx_cmd_i;
            next_word[emmc_link_pkg::CMD_OE_BIT] = tx_cmd_oe_i;
            next_word[emmc_link_pkg::DAT_OE_BIT] = tx_dat_oe_i;
            next_word[emmc_link_pkg::DAT_HI:emmc_link_pkg::DAT_LO] = tx_dat_i;
        end
    end

    ////////////////////////////////////////
    // Handshake FSM
    ////////////////////////////////////////

    always_ff @(posedge txclk_div) begin
        if (!rst) begin
            state       <= PK_IDLE;
            data_word_o <= '0;                              // Idles go out first
        end else begin
            case (state)
                PK_IDLE: begin
                    if (accept) begin
                        state <= PK_LATCHED;
                    end
                end
                PK_LATCHED: state <= PK_ACK;                // Ack rises one cycle after latch
                PK_ACK: begin
                    if (!tx_req_i) begin
                        state <= PK_IDLE;                   // Ack falls next cycle
                    end
                end
                default: state <= PK_IDLE;
            endcase
            if (frame_start_i) begin
                data_word_o <= next_word;                   // Serializer loads it at count zero
            end
        end
    end

    // Host must hold req while the packer is about to acknowledge
    a_ack_needs_req: assert property (@(posedge txclk_div) disable iff (!rst)
        (!tx_ack_o && !tx_req_i) |=> !tx_ack_o)
        else $error("tx_ack_o rose while tx_req_i was low");

endmodule

//--- emmc_link_pkg.sv
package emmc_link_pkg;

    ////////////////////////////////////////
    // Frame geometry
    ////////////////////////////////////////

    localparam int FRAME_BITS = 8;                       // Serial bits per frame word

    typedef logic [FRAME_BITS-1:0]         frame_word_t; // One word on a lane
    typedef logic [3:0]                    emmc_dat_t;   // eMMC DAT[3:0]
    typedef logic [$clog2(FRAME_BITS)-1:0] bit_cnt_t;    // Bit position inside a frame

    // Last bit position, the counter wraps after it
    localparam bit_cnt_t LAST_BIT = bit_cnt_t'(FRAME_BITS - 1);

    ////////////////////////////////////////
    // Lane contents
    ////////////////////////////////////////

    // Training lane repeats this word forever
    // No rotation of C3 equals C3, so the match marks exactly one boundary
    localparam frame_word_t TRAIN_PATTERN = 8'hC3;

    // Data word layout, MSB goes out first
    localparam int VALID_BIT  = 7;   // Set only for words that carry host fields
    localparam int CMD_BIT    = 6;   // CMD line level
    localparam int CMD_OE_BIT = 5;   // CMD output enable
    localparam int DAT_OE_BIT = 4;   // Shared output enable of DAT[3:0]
    localparam int DAT_HI     = 3;   // DAT bus upper bit
    localparam int DAT_LO     = 0;   // DAT bus lower bit

    ////////////////////////////////////////
    // Receiver alignment
    ////////////////////////////////////////

    typedef enum logic [2:0] {
        SLIP,    // One-cycle slip pulse to the deserializer
        WAIT_A,  // Waiting for the first strobe after a slip
        WAIT_B,  // Counting the remaining settle strobes
        CHECK,   // Next strobe is compared against the pattern
        LOCKED   // Boundary found, held until reset
    } align_state_t;

endpackage
